// ==== hw/rx_fwd_pkg.sv ====
package rx_fwd_pkg;

    // byte stream from the mac with one byte per beat
    localparam int BEAT_W      = 8;
    localparam int KEEP_W      = BEAT_W / 8;   // one valid bit per byte
    localparam int PORT_MASK_W = 8;            // metadata port bitmap width
    localparam int ETHERTYPE_W = 16;

    // one data beat
    typedef logic [BEAT_W-1:0]      beat_t;

    // byte-valid mask of a beat
    typedef logic [KEEP_W-1:0]      keep_t;

    // port bitmap as carried in the metadata
    // narrower PORT_NUM masks get zero padded into this
    typedef logic [PORT_MASK_W-1:0] port_mask_t;

    // raw ethertype from the parser
    typedef logic [ETHERTYPE_W-1:0] ethertype_t;

endpackage

// ==== hw/rx_meta_pkg.sv ====
package rx_meta_pkg;

    localparam int META_W = 81;

    typedef logic [META_W-1:0] metadata_t;

    // lsb and width of each metadata field
    // bits 35:28, 18:15 and 3:0 are reserved and stay zero
    localparam int META_RTAG_LSB  = 65;
    localparam int META_RTAG_W    = 16;
    localparam int META_SPEED_LSB = 63;
    localparam int META_SPEED_W   = 2;
    localparam int META_VPRI_LSB  = 60;
    localparam int META_VPRI_W    = 3;
    localparam int META_TXP_LSB   = 52;
    localparam int META_TXP_W     = 8;
    localparam int META_FTYPE_LSB = 44;
    localparam int META_FTYPE_W   = 8;
    localparam int META_SH_LSB    = 36;
    localparam int META_SH_W      = 8;
    localparam int META_VLAN_BIT  = 27;
    localparam int META_RXP_LSB   = 19;
    localparam int META_RXP_W     = 8;
    localparam int META_CBOP_LSB  = 13;
    localparam int META_CBOP_W    = 2;
    localparam int META_DISC_BIT  = 12;
    localparam int META_QBU_BIT   = 11;
    localparam int META_TS_LSB    = 4;
    localparam int META_TS_W      = 7;

    // ethertypes with their own frame type
    localparam logic [15:0] ETH_PTP  = 16'h88F7;  // 802.1AS
    localparam logic [15:0] ETH_LLDP = 16'h88CC;
    localparam logic [15:0] ETH_RSTP = 16'h010B;

    typedef enum logic [7:0] {
        OTHER = 8'd0,
        PTP   = 8'd1,
        LLDP  = 8'd2,
        RSTP  = 8'd3
    } frm_type_e;

    // acl result action code
    typedef enum logic [2:0] {
        PASS     = 3'd0,
        DROP     = 3'd1,
        REDIRECT = 3'd2
    } acl_action_e;

endpackage

// ==== hw/rx_frame_fifo.sv ====
`timescale 1ns/10ps

module rx_frame_fifo
    import rx_fwd_pkg::*;
#(
    parameter int FIFO_DEPTH = 64
) (
    input  logic  i_clk,
    input  logic  i_rst,
    input  logic  i_wr_en,
    input  beat_t i_data,
    input  keep_t i_keep,
    input  logic  i_last,
    output logic  o_full,
    input  logic  i_rd_en,
    output beat_t o_data,
    output keep_t o_keep,
    output logic  o_last,
    output logic  o_empty
);

    localparam int AW = $clog2(FIFO_DEPTH);

    beat_t       mem_data [FIFO_DEPTH];
    keep_t       mem_keep [FIFO_DEPTH];
    logic        mem_last [FIFO_DEPTH];
    logic [AW:0] r_wr_ptr;  // extra msb tells wrap
    logic [AW:0] r_rd_ptr;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
        end else begin
            if (i_wr_en)
                r_wr_ptr <= r_wr_ptr + 1'b1;
            if (i_rd_en)
                r_rd_ptr <= r_rd_ptr + 1'b1;
        end
    end

    // entry storage
    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem_data[r_wr_ptr[AW-1:0]] <= i_data;
            mem_keep[r_wr_ptr[AW-1:0]] <= i_keep;
            mem_last[r_wr_ptr[AW-1:0]] <= i_last;
        end
    end

    assign o_empty = (r_wr_ptr == r_rd_ptr);
    assign o_full  = (r_wr_ptr[AW] != r_rd_ptr[AW]) &&
                     (r_wr_ptr[AW-1:0] == r_rd_ptr[AW-1:0]);  // same slot on the other lap

    // fall-through head
    assign o_data = mem_data[r_rd_ptr[AW-1:0]];
    assign o_keep = mem_keep[r_rd_ptr[AW-1:0]];
    assign o_last = mem_last[r_rd_ptr[AW-1:0]];

    a_no_overflow: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wr_en |-> !o_full) else $error("fifo write while full");

    a_no_underflow: assert property (@(posedge i_clk) disable iff (i_rst)
        i_rd_en |-> !o_empty) else $error("fifo read while empty");

endmodule

// ==== hw/rx_meta_builder.sv ====
`timescale 1ns/10ps

module rx_meta_builder
    import rx_fwd_pkg::*;
    import rx_meta_pkg::*;
#(
    parameter int PORT_NUM   = 4,
    parameter int PORT_INDEX = 0
) (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_info_valid,
    input  logic                i_rtag_flag,
    input  logic [15:0]         i_rtag_sequence,
    input  logic [1:0]          i_port_speed,
    input  logic [2:0]          i_vlan_pri,
    input  logic                i_frm_vlan_flag,
    input  logic                i_frm_discard,     // crc discard
    input  logic                i_frm_qbu,
    input  logic [6:0]          i_timestamp_addr,
    input  ethertype_t          i_ethertype,
    input  logic                i_swlist_vld,
    input  logic [PORT_NUM-1:0] i_swlist_tx_port,
    input  logic                i_acl_vld,
    input  logic [2:0]          i_acl_action,
    input  logic                i_acl_cb_frm,
    input  logic [7:0]          i_acl_cb_streamhandle,
    input  port_mask_t          i_acl_forwardport,
    input  logic                i_meta_take,
    output logic                o_meta_ready,
    output metadata_t           o_metadata
);

    localparam port_mask_t RX_PORT = port_mask_t'(1) << PORT_INDEX;  // own port as one-hot

    // captured frame info
    logic                r_rtag_flag;
    logic [15:0]         r_rtag_seq;
    logic [1:0]          r_port_speed;
    logic [2:0]          r_vlan_pri;
    logic                r_vlan_flag;
    logic                r_frm_discard;
    logic                r_frm_qbu;
    logic [6:0]          r_ts_addr;
    ethertype_t          r_ethertype;
    // captured lookup results
    logic [PORT_NUM-1:0] r_swlist_port;
    acl_action_e         r_acl_action;
    logic                r_acl_cb_frm;
    logic [7:0]          r_acl_sh;
    port_mask_t          r_acl_fwd;
    // control
    logic                r_sw_seen;
    logic                r_acl_seen;
    logic                r_hold;      // word built and frozen until take
    frm_type_e           frm_type;
    port_mask_t          tx_port;
    metadata_t           meta_next;

    always_ff @(posedge i_clk) begin
        if (i_info_valid) begin
            r_rtag_flag   <= i_rtag_flag;
            r_rtag_seq    <= i_rtag_sequence;
            r_port_speed  <= i_port_speed;
            r_vlan_pri    <= i_vlan_pri;
            r_vlan_flag   <= i_frm_vlan_flag;
            r_frm_discard <= i_frm_discard;
            r_frm_qbu     <= i_frm_qbu;
            r_ts_addr     <= i_timestamp_addr;
            r_ethertype   <= i_ethertype;
        end
        if (i_swlist_vld)
            r_swlist_port <= i_swlist_tx_port;
        if (i_acl_vld) begin
            r_acl_action <= acl_action_e'(i_acl_action);
            r_acl_cb_frm <= i_acl_cb_frm;
            r_acl_sh     <= i_acl_cb_streamhandle;
            r_acl_fwd    <= i_acl_forwardport;
        end
    end

    // sticky lookup flags; a new strobe on the take cycle belongs to the next frame
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_sw_seen  <= 1'b0;
            r_acl_seen <= 1'b0;
            r_hold     <= 1'b0;
        end else begin
            if (i_swlist_vld)
                r_sw_seen <= 1'b1;
            else if (i_meta_take)
                r_sw_seen <= 1'b0;
            if (i_acl_vld)
                r_acl_seen <= 1'b1;
            else if (i_meta_take)
                r_acl_seen <= 1'b0;
            r_hold <= o_meta_ready & ~i_meta_take;
        end
    end

    assign o_meta_ready = r_sw_seen & r_acl_seen;

    always_comb begin
        case (r_ethertype)
            ETH_PTP:  frm_type = PTP;
            ETH_LLDP: frm_type = LLDP;
            ETH_RSTP: frm_type = RSTP;
            default:  frm_type = OTHER;
        endcase
    end

    // acl forward port wins when set
    assign tx_port = (r_acl_fwd != '0) ? r_acl_fwd : port_mask_t'(r_swlist_port);

    always_comb begin
        meta_next = '0;   // reserved bits zero
        meta_next[META_RTAG_LSB  +: META_RTAG_W]  = r_rtag_seq;
        meta_next[META_SPEED_LSB +: META_SPEED_W] = r_port_speed;
        meta_next[META_VPRI_LSB  +: META_VPRI_W]  = r_vlan_pri;
        meta_next[META_TXP_LSB   +: META_TXP_W]   = tx_port;
        meta_next[META_FTYPE_LSB +: META_FTYPE_W] = frm_type;
        meta_next[META_SH_LSB    +: META_SH_W]    = r_acl_sh;
        meta_next[META_VLAN_BIT]                  = r_vlan_flag;
        meta_next[META_RXP_LSB   +: META_RXP_W]   = RX_PORT;
        meta_next[META_CBOP_LSB  +: META_CBOP_W]  = {r_rtag_flag, r_acl_cb_frm};
        meta_next[META_DISC_BIT]                  = r_frm_discard | (r_acl_action == DROP);
        meta_next[META_QBU_BIT]                   = r_frm_qbu;
        meta_next[META_TS_LSB    +: META_TS_W]    = r_ts_addr;
    end

    // payload word tracks captures until both lookups are in
    always_ff @(posedge i_clk) begin
        if (!r_hold)
            o_metadata <= meta_next;
    end

    // each lookup once per frame with a take in between
    a_one_lookup: assert property (@(posedge i_clk) disable iff (i_rst)
        ((i_swlist_vld && r_sw_seen) || (i_acl_vld && r_acl_seen)) |-> i_meta_take)
        else $error("second lookup strobe before metadata taken");

endmodule

// ==== hw/rx_release_ctrl.sv ====
`timescale 1ns/10ps

module rx_release_ctrl
    import rx_fwd_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst,
    input  logic  i_meta_ready,
    output logic  o_meta_take,
    input  logic  i_fifo_empty,
    output logic  o_fifo_rd_en,
    input  beat_t i_fifo_data,
    input  keep_t i_fifo_keep,
    input  logic  i_fifo_last,
    output beat_t o_data,
    output keep_t o_keep,
    output logic  o_valid,
    output logic  o_last,
    input  logic  i_ready,
    output logic  o_meta_valid,
    output logic  o_meta_last,
    input  logic  i_meta_out_ready   // downstream metadata ready
);

    typedef enum logic {
        IDLE,
        SEND
    } state_e;

    state_e r_state;
    logic   out_free;     // output reg empty or being taken this cycle
    logic   r_meta_pulse;

    assign out_free = ~o_valid | i_ready;

    // pull from the fifo head
    always_comb begin
        o_fifo_rd_en = 1'b0;
        case (r_state)
            IDLE:    o_fifo_rd_en = i_meta_ready & ~i_fifo_empty & out_free;  // frame start
            SEND:    o_fifo_rd_en = ~i_fifo_empty & out_free;
            default: o_fifo_rd_en = 1'b0;
        endcase
    end

    // first read of a frame consumes its metadata
    assign o_meta_take = (r_state == IDLE) & o_fifo_rd_en;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_state <= IDLE;
        end else if (o_fifo_rd_en && i_fifo_last) begin
            r_state <= IDLE;   // frame done so wait for next lookups
        end else if (o_meta_take) begin
            r_state <= SEND;
        end
    end

    // output beat register
    always_ff @(posedge i_clk) begin
        if (i_rst)
            o_valid <= 1'b0;
        else if (o_fifo_rd_en)
            o_valid <= 1'b1;
        else if (i_ready)
            o_valid <= 1'b0;   // beat taken with nothing behind it
    end

    always_ff @(posedge i_clk) begin
        if (o_fifo_rd_en) begin
            o_data <= i_fifo_data;
            o_keep <= i_fifo_keep;
            o_last <= i_fifo_last;
        end
    end

    // metadata pulse lines up with the first beat showing up
    always_ff @(posedge i_clk) begin
        if (i_rst)
            r_meta_pulse <= 1'b0;
        else
            r_meta_pulse <= o_meta_take;
    end

    assign o_meta_valid = r_meta_pulse;
    assign o_meta_last  = r_meta_pulse;  // single word per frame

    a_out_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_valid && !i_ready) |=> (o_valid && $stable(o_data) && $stable(o_last)))
        else $error("output beat changed under back-pressure");

    // metadata has no back-pressure path
    a_meta_no_bp: assert property (@(posedge i_clk) disable iff (i_rst)
        o_meta_valid |-> i_meta_out_ready)
        else $error("metadata pulse while downstream not ready");

endmodule

// ==== hw/rx_forward_mng.sv ====
`timescale 1ns/10ps

module rx_forward_mng
    import rx_fwd_pkg::*;
    import rx_meta_pkg::*;
#(
    parameter int PORT_NUM   = 4,    // max 8
    parameter int PORT_INDEX = 0,
    parameter int FIFO_DEPTH = 64    // power of two
) (
    input  logic                i_clk,
    input  logic                i_rst,
    // frame info strobe
    input  logic                i_info_valid,
    input  logic                i_rtag_flag,
    input  logic [15:0]         i_rtag_sequence,
    input  logic [1:0]          i_port_speed,
    input  logic [2:0]          i_vlan_pri,
    input  logic                i_frm_vlan_flag,
    input  logic                i_frm_discard,
    input  logic                i_frm_qbu,
    input  logic [6:0]          i_timestamp_addr,
    input  ethertype_t          i_ethertype,
    // lookups
    input  logic                i_swlist_vld,
    input  logic [PORT_NUM-1:0] i_swlist_tx_port,
    input  logic                i_acl_vld,
    input  logic [2:0]          i_acl_action,
    input  logic                i_acl_cb_frm,
    input  logic [7:0]          i_acl_cb_streamhandle,
    input  port_mask_t          i_acl_forwardport,
    // beats from the mac
    input  beat_t               i_mac_port_axi_data,
    input  keep_t               i_mac_axi_data_keep,
    input  logic                i_mac_axi_data_valid,
    input  logic                i_mac_axi_data_last,
    output logic                o_mac_axi_data_ready,
    // beats downstream
    output beat_t               o_mac_port_axi_data,
    output keep_t               o_mac_axi_data_keep,
    output logic                o_mac_axi_data_valid,
    output logic                o_mac_axi_data_last,
    input  logic                i_mac_axi_data_ready,
    // metadata pulse
    output metadata_t           o_cross_metadata,
    output logic                o_cross_metadata_valid,
    output logic                o_cross_metadata_last,
    input  logic                i_cross_metadata_ready
);

    logic  fifo_wr_en;
    logic  fifo_full;
    logic  fifo_rd_en;
    logic  fifo_empty;
    beat_t fifo_data;
    keep_t fifo_keep;
    logic  fifo_last;
    logic  meta_ready;
    logic  meta_take;

    assign fifo_wr_en           = i_mac_axi_data_valid & ~fifo_full;
    assign o_mac_axi_data_ready = ~fifo_full;

    rx_frame_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_wr_en (fifo_wr_en),
        .i_data  (i_mac_port_axi_data),
        .i_keep  (i_mac_axi_data_keep),
        .i_last  (i_mac_axi_data_last),
        .o_full  (fifo_full),
        .i_rd_en (fifo_rd_en),
        .o_data  (fifo_data),
        .o_keep  (fifo_keep),
        .o_last  (fifo_last),
        .o_empty (fifo_empty)
    );

    rx_meta_builder #(
        .PORT_NUM   (PORT_NUM),
        .PORT_INDEX (PORT_INDEX)
    ) u_meta (
        .i_clk                 (i_clk),
        .i_rst                 (i_rst),
        .i_info_valid          (i_info_valid),
        .i_rtag_flag           (i_rtag_flag),
        .i_rtag_sequence       (i_rtag_sequence),
        .i_port_speed          (i_port_speed),
        .i_vlan_pri            (i_vlan_pri),
        .i_frm_vlan_flag       (i_frm_vlan_flag),
        .i_frm_discard         (i_frm_discard),
        .i_frm_qbu             (i_frm_qbu),
        .i_timestamp_addr      (i_timestamp_addr),
        .i_ethertype           (i_ethertype),
        .i_swlist_vld          (i_swlist_vld),
        .i_swlist_tx_port      (i_swlist_tx_port),
        .i_acl_vld             (i_acl_vld),
        .i_acl_action          (i_acl_action),
        .i_acl_cb_frm          (i_acl_cb_frm),
        .i_acl_cb_streamhandle (i_acl_cb_streamhandle),
        .i_acl_forwardport     (i_acl_forwardport),
        .i_meta_take           (meta_take),
        .o_meta_ready          (meta_ready),
        .o_metadata            (o_cross_metadata)
    );

    rx_release_ctrl u_release (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .i_meta_ready     (meta_ready),
        .o_meta_take      (meta_take),
        .i_fifo_empty     (fifo_empty),
        .o_fifo_rd_en     (fifo_rd_en),
        .i_fifo_data      (fifo_data),
        .i_fifo_keep      (fifo_keep),
        .i_fifo_last      (fifo_last),
        .o_data           (o_mac_port_axi_data),
        .o_keep           (o_mac_axi_data_keep),
        .o_valid          (o_mac_axi_data_valid),
        .o_last           (o_mac_axi_data_last),
        .i_ready          (i_mac_axi_data_ready),
        .o_meta_valid     (o_cross_metadata_valid),
        .o_meta_last      (o_cross_metadata_last),
        .i_meta_out_ready (i_cross_metadata_ready)
    );

endmodule

// ==== tests/rx_fwd_checker.sv ====
`timescale 1ns/10ps

module rx_fwd_checker
    import rx_fwd_pkg::*;
    import rx_meta_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst,
    input  beat_t     i_data,
    input  keep_t     i_keep,
    input  logic      i_valid,
    input  logic      i_last,
    input  logic      i_ready,
    input  metadata_t i_meta,
    input  logic      i_meta_valid,
    input  logic      i_meta_last,
    input  int        i_lookups_done,   // frames whose second strobe is driven
    output int        o_frames_done,
    output int        o_data_errs,
    output int        o_meta_errs,
    output int        o_proto_errs,
    output int        o_pending
);

    logic [KEEP_W+BEAT_W:0] exp_beats [$];  // {keep, last, data}
    metadata_t              exp_meta  [$];
    int                     n_meta;         // metadata pulses seen
    int                     n_beat;         // beat index inside the frame

    task automatic expect_beat(input beat_t d, input keep_t k, input logic l);
        exp_beats.push_back({k, l, d});
    endtask

    task automatic expect_meta(input metadata_t m);
        exp_meta.push_back(m);
    endtask

    always @(posedge i_clk) begin
        logic [KEEP_W+BEAT_W:0] e;
        metadata_t              m;
        if (i_rst) begin
            n_meta        = 0;
            n_beat        = 0;
            o_frames_done = 0;
        end else begin
            if (i_meta_valid != i_meta_last) begin
                o_proto_errs++;
                $display("%0t: metadata valid and last are not one pulse", $time);
            end
            if (i_meta_valid) begin
                if (n_meta != o_frames_done) begin
                    o_proto_errs++;
                    $display("%0t: second metadata pulse inside frame %0d", $time, n_meta);
                end
                if (i_lookups_done <= n_meta) begin
                    o_proto_errs++;
                    $display("%0t: metadata before both lookups of frame %0d", $time, n_meta);
                end
                if (!i_valid) begin
                    o_proto_errs++;
                    $display("%0t: metadata pulse without the first beat", $time);
                end
                if (exp_meta.size() == 0) begin
                    o_proto_errs++;
                    $display("%0t: metadata pulse that no frame asked for", $time);
                end else begin
                    m = exp_meta.pop_front();
                    if (i_meta !== m) begin
                        o_meta_errs++;
                        $display("Fail %0t: frame %0d metadata %h, expected %h",
                                 $time, n_meta, i_meta, m);
                    end
                end
                n_meta++;
            end
            // any valid needs its frame's metadata first
            if (i_valid && n_meta <= o_frames_done) begin
                o_proto_errs++;
                $display("%0t: output valid before metadata of frame %0d", $time, n_meta);
            end
            if (i_valid && i_ready) begin
                if (exp_beats.size() == 0) begin
                    o_proto_errs++;
                    $display("%0t: extra output beat %h", $time, i_data);
                end else begin
                    e = exp_beats.pop_front();
                    if ({i_keep, i_last, i_data} !== e) begin
                        o_data_errs++;
                        // keep, last and data in that order
                        $display("Fail %0t: frame %0d beat %0d got %b %b %h, expected %b %b %h",
                                 $time, o_frames_done, n_beat, i_keep, i_last, i_data,
                                 e[BEAT_W+1], e[BEAT_W], e[BEAT_W-1:0]);
                    end
                    n_beat++;
                    if (e[BEAT_W]) begin   // expected last closes the frame
                        o_frames_done++;
                        n_beat = 0;
                    end
                end
            end
        end
        o_pending = exp_beats.size();
    end

endmodule

// ==== tests/tb_rx_forward_mng.sv ====
`timescale 1ns/10ps

module tb_rx_forward_mng;

    localparam int PORT_NUM   = 4;
    localparam int PORT_INDEX = 0;
    localparam int FIFO_DEPTH = 64;
    localparam int N_FRAMES   = 8;

    // one row per frame
    typedef struct packed {
        logic [7:0]  len;        // bytes
        logic [15:0] etype;
        logic        crc_disc;
        logic [2:0]  action;     // 0 pass, 1 drop, 2 redirect
        logic [7:0]  acl_fwd;
        logic [3:0]  sw_port;
        logic        acl_first;  // lookup order
        logic [7:0]  dly;        // cycles from info to first lookup
        logic [7:0]  exp_type;   // 0 other, 1 ptp, 2 lldp, 3 rstp
    } frame_row_t;

    logic                i_clk;
    logic                i_rst;
    logic                i_info_valid;
    logic                i_rtag_flag;
    logic [15:0]         i_rtag_sequence;
    logic [1:0]          i_port_speed;
    logic [2:0]          i_vlan_pri;
    logic                i_frm_vlan_flag;
    logic                i_frm_discard;
    logic                i_frm_qbu;
    logic [6:0]          i_timestamp_addr;
    logic [15:0]         i_ethertype;
    logic                i_swlist_vld;
    logic [PORT_NUM-1:0] i_swlist_tx_port;
    logic                i_acl_vld;
    logic [2:0]          i_acl_action;
    logic                i_acl_cb_frm;
    logic [7:0]          i_acl_cb_streamhandle;
    logic [7:0]          i_acl_forwardport;
    logic [7:0]          i_mac_port_axi_data;
    logic                i_mac_axi_data_keep;
    logic                i_mac_axi_data_valid;
    logic                i_mac_axi_data_last;
    logic                o_mac_axi_data_ready;
    logic [7:0]          o_mac_port_axi_data;
    logic                o_mac_axi_data_keep;
    logic                o_mac_axi_data_valid;
    logic                o_mac_axi_data_last;
    logic                i_mac_axi_data_ready;
    logic [80:0]         o_cross_metadata;
    logic                o_cross_metadata_valid;
    logic                o_cross_metadata_last;
    logic                i_cross_metadata_ready;

    logic [15:0] lfsr_q;
    int          lookups_done;
    int          frames_done;
    int          data_errs;
    int          meta_errs;
    int          proto_errs;
    int          pending;
    int          other_errs;   // stall, reset and missing frame checks

    rx_forward_mng #(
        .PORT_NUM   (PORT_NUM),
        .PORT_INDEX (PORT_INDEX),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut (.*);

    rx_fwd_checker u_chk (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_data         (o_mac_port_axi_data),
        .i_keep         (o_mac_axi_data_keep),
        .i_valid        (o_mac_axi_data_valid),
        .i_last         (o_mac_axi_data_last),
        .i_ready        (i_mac_axi_data_ready),
        .i_meta         (o_cross_metadata),
        .i_meta_valid   (o_cross_metadata_valid),
        .i_meta_last    (o_cross_metadata_last),
        .i_lookups_done (lookups_done),
        .o_frames_done  (frames_done),
        .o_data_errs    (data_errs),
        .o_meta_errs    (meta_errs),
        .o_proto_errs   (proto_errs),
        .o_pending      (pending)
    );

    // len, etype, crc, action, acl fwd, sw port, acl first, delay, type
    function automatic frame_row_t frame_row(input int i);
        case (i)
            0:       return '{8'd12, 16'h88F7, 1'b0, 3'd0, 8'h00, 4'b0010, 1'b0, 8'd3,   8'd1};
            1:       return '{8'd20, 16'h88CC, 1'b1, 3'd0, 8'h00, 4'b0100, 1'b1, 8'd30,  8'd2};
            2:       return '{8'd1,  16'h010B, 1'b0, 3'd1, 8'h00, 4'b1000, 1'b0, 8'd5,   8'd3};
            3:       return '{8'd33, 16'h0800, 1'b0, 3'd2, 8'h04, 4'b0001, 1'b1, 8'd1,   8'd0};
            4:       return '{8'd70, 16'h86DD, 1'b0, 3'd0, 8'h00, 4'b0110, 1'b0, 8'd100, 8'd0};
            5:       return '{8'd9,  16'h88F7, 1'b1, 3'd1, 8'h80, 4'b0011, 1'b1, 8'd12,  8'd1};
            6:       return '{8'd64, 16'h0806, 1'b0, 3'd2, 8'h0A, 4'b0001, 1'b0, 8'd20,  8'd0};
            default: return '{8'd2,  16'h88CC, 1'b0, 3'd0, 8'h00, 4'b1111, 1'b1, 8'd2,   8'd2};
        endcase
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    // 4 cycles per byte plus slack per frame
    function automatic int cycle_limit();
        frame_row_t r;
        int         total;
        total = 0;
        for (int i = 0; i < N_FRAMES; i++) begin
            r = frame_row(i);
            total += 4 * int'(r.len) + 200;
        end
        return total;
    endfunction

    // step one cycle and redraw output ready 1 ns after the edge
    task automatic tick();
        logic [31:0] v;
        @(posedge i_clk);
        #1;
        rand_bits(2, v);
        i_mac_axi_data_ready = (v[1:0] != 2'b00);   // ready 3 of 4 cycles
    endtask

    task automatic print_counts();
        $display("errors: data %0d, metadata %0d, protocol %0d, other %0d",
                 data_errs, meta_errs, proto_errs, other_errs);
    endtask

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    initial begin
        int cycles;
        int limit;
        cycles = 0;
        limit  = cycle_limit();
        while (cycles < limit) begin
            @(posedge i_clk);
            cycles++;
        end
        $display("timeout: run still going after %0d cycles", limit);
        print_counts();
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        frame_row_t  row;
        logic [31:0] v;
        logic [80:0] exp_m;
        logic [7:0]  exp_tx;
        logic        exp_disc;
        logic        acc;
        int          c;
        int          sent;
        int          len;
        int          dly;
        int          stall_at;

        lfsr_q                 = 16'd58606;
        lookups_done           = 0;
        other_errs             = 0;
        i_rst                  = 1'b1;
        i_info_valid           = 1'b0;
        i_rtag_flag            = 1'b0;
        i_rtag_sequence        = '0;
        i_port_speed           = '0;
        i_vlan_pri             = '0;
        i_frm_vlan_flag        = 1'b0;
        i_frm_discard          = 1'b0;
        i_frm_qbu              = 1'b0;
        i_timestamp_addr       = '0;
        i_ethertype            = '0;
        i_swlist_vld           = 1'b0;
        i_swlist_tx_port       = '0;
        i_acl_vld              = 1'b0;
        i_acl_action           = '0;
        i_acl_cb_frm           = 1'b0;
        i_acl_cb_streamhandle  = '0;
        i_acl_forwardport      = '0;
        i_mac_port_axi_data    = '0;
        i_mac_axi_data_keep    = 1'b1;   // single byte beats are always valid
        i_mac_axi_data_valid   = 1'b0;
        i_mac_axi_data_last    = 1'b0;
        i_mac_axi_data_ready   = 1'b1;
        i_cross_metadata_ready = 1'b1;   // no metadata back-pressure

        repeat (10) tick();
        i_rst = 1'b0;
        if (!o_mac_axi_data_ready || o_mac_axi_data_valid || o_cross_metadata_valid) begin
            other_errs++;
            $display("%0t: outputs not in their reset state", $time);
        end

        for (int r = 0; r < N_FRAMES; r++) begin
            row = frame_row(r);
            len = int'(row.len);
            dly = int'(row.dly);
            // per frame info and lookup payload
            rand_bits(1, v);
            i_rtag_flag = v[0];
            rand_bits(16, v);
            i_rtag_sequence = v[15:0];
            rand_bits(2, v);
            i_port_speed = v[1:0];
            rand_bits(3, v);
            i_vlan_pri = v[2:0];
            rand_bits(1, v);
            i_frm_vlan_flag = v[0];
            rand_bits(1, v);
            i_frm_qbu = v[0];
            rand_bits(7, v);
            i_timestamp_addr = v[6:0];
            rand_bits(1, v);
            i_acl_cb_frm = v[0];
            rand_bits(8, v);
            i_acl_cb_streamhandle = v[7:0];
            i_frm_discard     = row.crc_disc;
            i_ethertype       = row.etype;
            i_acl_action      = row.action;
            i_acl_forwardport = row.acl_fwd;
            i_swlist_tx_port  = row.sw_port;

            // nonzero acl port wins and drop or crc error discards
            exp_tx   = (row.acl_fwd != 8'h00) ? row.acl_fwd : {4'h0, row.sw_port};
            exp_disc = row.crc_disc | (row.action == 3'd1);
            exp_m = {i_rtag_sequence, i_port_speed, i_vlan_pri, exp_tx, row.exp_type,
                     i_acl_cb_streamhandle, 8'h00, i_frm_vlan_flag,
                     8'(1) << PORT_INDEX, 4'h0, i_rtag_flag, i_acl_cb_frm,
                     exp_disc, i_frm_qbu, i_timestamp_addr, 4'h0};
            u_chk.expect_meta(exp_m);

            c        = 0;
            sent     = 0;
            stall_at = -1;
            acc      = 1'b0;
            while (sent < len || c <= dly + 3) begin
                tick();
                if (acc)
                    sent++;
                i_info_valid = (c == 0);   // with the first beat
                i_swlist_vld = (c == (row.acl_first ? dly + 2 : dly));
                i_acl_vld    = (c == (row.acl_first ? dly : dly + 2));
                if (c == dly + 2)
                    lookups_done++;
                if (sent < len) begin
                    if (!i_mac_axi_data_valid || acc) begin   // previous beat gone
                        rand_bits(8, v);
                        i_mac_port_axi_data = v[7:0];
                        i_mac_axi_data_last = (sent == len - 1);
                        u_chk.expect_beat(v[7:0], 1'b1, i_mac_axi_data_last);
                    end
                    i_mac_axi_data_valid = 1'b1;
                end else begin
                    i_mac_axi_data_valid = 1'b0;
                end
                // ready only moves at the edge, so this is what the dut will see
                acc = i_mac_axi_data_valid & o_mac_axi_data_ready;
                if (i_mac_axi_data_valid && !o_mac_axi_data_ready && stall_at < 0)
                    stall_at = sent;
                c++;
            end

            // long frame with late lookups must fill the fifo exactly
            if (len > FIFO_DEPTH && dly >= FIFO_DEPTH + 4 && stall_at != FIFO_DEPTH) begin
                other_errs++;
                $display("Fail %0t: frame %0d ready fell after %0d beats, expected %0d",
                         $time, r, stall_at, FIFO_DEPTH);
            end

            while (frames_done <= r)
                tick();
        end

        repeat (20) tick();   // room for stray beats
        if (frames_done != N_FRAMES || pending != 0) begin
            other_errs++;
            $display("%0t: %0d of %0d frames came out, %0d beats never seen",
                     $time, frames_done, N_FRAMES, pending);
        end
        print_counts();
        if (data_errs + meta_errs + proto_errs + other_errs == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== project.f ====
hw/rx_fwd_pkg.sv
hw/rx_meta_pkg.sv
hw/rx_frame_fifo.sv
hw/rx_meta_builder.sv
hw/rx_release_ctrl.sv
hw/rx_forward_mng.sv
tests/rx_fwd_checker.sv
tests/tb_rx_forward_mng.sv

// ==== run.sh ====
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_rx_forward_mng -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "RESULT: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
